/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  cpu_pkg::alu_op_t i_op,
   input  cpu_pkg::word_t   i_a,
   input  cpu_pkg::word_t   i_b,
   output cpu_pkg::word_t   o_result
);
   import cpu_pkg::*;

   always_comb begin
      case (i_op)
         // Arithmetic
         ALU_ADD: o_result = i_a + i_b;
         ALU_SUB: o_result = i_a - i_b;
         // Bitwise
         ALU_AND: o_result = i_a & i_b;
         ALU_ORR: o_result = i_a | i_b;
         ALU_NOT: o_result = ~i_a;
         // Negate A
         ALU_TCP: o_result = ~i_a + word_t'(1);
         // Shifts by one, right keeps the sign
         ALU_SHL: o_result = {i_a[$bits(word_t)-2:0], 1'b0};
         ALU_SHR: o_result = {i_a[$bits(word_t)-1], i_a[$bits(word_t)-1:1]};
         // LHI immediate passes straight through
         ALU_PASS_B: o_result = i_b;
         default: o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module control_decoder (
   input  cpu_pkg::inst_t i_inst,
   output cpu_pkg::ctrl_t o_ctrl
);
   import cpu_pkg::*;

   always_comb begin
      // Bubble unless a known encoding matches
      o_ctrl.alu_op    = ALU_ADD;
      o_ctrl.b_src     = B_REG;
      o_ctrl.reg_write = 1'b0;
      o_ctrl.wb_src    = WB_ALU;
      o_ctrl.write_reg = i_inst.i.rt;
      o_ctrl.mem_read  = 1'b0;
      o_ctrl.mem_write = 1'b0;
      o_ctrl.out_write = 1'b0;
      o_ctrl.halt      = 1'b0;

      case (i_inst.r.opcode)
         `OPCODE_RTYPE: begin
            // ALU ops write rd
            o_ctrl.write_reg = i_inst.r.rd;
            case (i_inst.r.func)
               `FUNC_ADD: o_ctrl.alu_op = ALU_ADD;
               `FUNC_SUB: o_ctrl.alu_op = ALU_SUB;
               `FUNC_AND: o_ctrl.alu_op = ALU_AND;
               `FUNC_ORR: o_ctrl.alu_op = ALU_ORR;
               `FUNC_NOT: o_ctrl.alu_op = ALU_NOT;
               `FUNC_TCP: o_ctrl.alu_op = ALU_TCP;
               `FUNC_SHL: o_ctrl.alu_op = ALU_SHL;
               `FUNC_SHR: o_ctrl.alu_op = ALU_SHR;
               default:   o_ctrl.alu_op = ALU_ADD;
            endcase
            // Only the eight ALU functions write back
            o_ctrl.reg_write = (i_inst.r.func <= `FUNC_SHR);
            // rs goes straight to the output port
            o_ctrl.out_write = (i_inst.r.func == `FUNC_WWD);
            o_ctrl.halt      = (i_inst.r.func == `FUNC_HLT);
         end
         `OPCODE_ADI: begin
            o_ctrl.alu_op    = ALU_ADD;
            o_ctrl.b_src     = B_IMM_SIGNED;
            o_ctrl.reg_write = 1'b1;
         end
         `OPCODE_ORI: begin
            o_ctrl.alu_op    = ALU_ORR;
            o_ctrl.b_src     = B_IMM_ZERO;
            o_ctrl.reg_write = 1'b1;
         end
         `OPCODE_LHI: begin
            // Constant into the upper byte, rs unused
            o_ctrl.alu_op    = ALU_PASS_B;
            o_ctrl.b_src     = B_IMM_HIGH;
            o_ctrl.reg_write = 1'b1;
         end
         `OPCODE_LWD: begin
            // Address is rs + sign-extended offset
            o_ctrl.b_src     = B_IMM_SIGNED;
            o_ctrl.reg_write = 1'b1;
            o_ctrl.wb_src    = WB_MEM;
            o_ctrl.mem_read  = 1'b1;
         end
         `OPCODE_SWD: begin
            o_ctrl.b_src     = B_IMM_SIGNED;
            o_ctrl.mem_write = 1'b1;
         end
         default: begin
            // Unknown opcode, keep the bubble
         end
      endcase
   end

endmodule

`default_nettype wire

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath sizes
`define WORD_SIZE   16
`define REG_ADDR_W  2
`define NUM_REGS    4

////////////////////////////////////////////////////////////////////////////
// Major opcodes, instruction bits [15:12]
////////////////////////////////////////////////////////////////////////////
`define OPCODE_RTYPE 4'd15
`define OPCODE_ADI   4'd4
`define OPCODE_ORI   4'd5
`define OPCODE_LHI   4'd6
`define OPCODE_LWD   4'd7
`define OPCODE_SWD   4'd8

////////////////////////////////////////////////////////////////////////////
// R-type function codes, instruction bits [5:0]
////////////////////////////////////////////////////////////////////////////
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_NOT 6'd4
`define FUNC_TCP 6'd5
`define FUNC_SHL 6'd6
`define FUNC_SHR 6'd7
// Output port write and halt
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

`endif

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

   // Basic words
   typedef logic [`WORD_SIZE-1:0]  word_t;
   typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction word, two decodings of the same 16 bits
   ////////////////////////////////////////////////////////////////////////////
   typedef union packed {
      // Register form
      struct packed {
         logic [3:0] opcode;
         reg_idx_t   rs;
         reg_idx_t   rt;
         reg_idx_t   rd;
         logic [5:0] func;
      } r;
      // Immediate form, low byte is the constant
      struct packed {
         logic [3:0] opcode;
         reg_idx_t   rs;
         reg_idx_t   rt;
         logic [7:0] imm8;
      } i;
   } inst_t;

   // ALU operations, first eight follow the function code order
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_ORR    = 4'd3,
      ALU_NOT    = 4'd4,
      ALU_TCP    = 4'd5,
      ALU_SHL    = 4'd6,
      ALU_SHR    = 4'd7,
      ALU_PASS_B = 4'd8
   } alu_op_t;

   // Second ALU operand
   typedef enum logic [1:0] {
      B_REG        = 2'd0,
      B_IMM_SIGNED = 2'd1,
      B_IMM_ZERO   = 2'd2,
      B_IMM_HIGH   = 2'd3
   } b_src_t;

   // Writeback value source
   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wb_src_t;

   // Operand source in EX
   typedef enum logic [1:0] {
      FWD_RF  = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_src_t;

   ////////////////////////////////////////////////////////////////////////////
   // Control bundle and stage registers
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      alu_op_t  alu_op;
      b_src_t   b_src;
      logic     reg_write;
      wb_src_t  wb_src;
      reg_idx_t write_reg;
      logic     mem_read;
      logic     mem_write;
      logic     out_write;
      logic     halt;
   } ctrl_t;

   typedef struct packed {
      ctrl_t      ctrl;
      word_t      a;
      word_t      b;
      logic [7:0] imm8;
      reg_idx_t   rs;
      reg_idx_t   rt;
   } id_ex_t;

   typedef struct packed {
      logic     reg_write;
      wb_src_t  wb_src;
      reg_idx_t write_reg;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    alu_out;
      word_t    store_data;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_write;
      reg_idx_t write_reg;
      logic     halt;
      word_t    wb_data;
   } mem_wb_t;

endpackage

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   input  cpu_pkg::reg_idx_t i_rs,
   input  cpu_pkg::reg_idx_t i_rt,
   input  logic              i_uses_rs,
   input  logic              i_uses_rt,
   input  cpu_pkg::id_ex_t   i_id_ex,
   input  cpu_pkg::ex_mem_t  i_ex_mem,
   input  cpu_pkg::mem_wb_t  i_mem_wb,
   output logic              o_stall,
   output cpu_pkg::fwd_src_t o_fwd_a,
   output cpu_pkg::fwd_src_t o_fwd_b
);
   import cpu_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Load-use detection
   ////////////////////////////////////////////////////////////////////////////

   logic rs_hit;
   logic rt_hit;

   // Load in EX whose target ID needs now
   assign rs_hit  = i_uses_rs && (i_id_ex.ctrl.write_reg == i_rs);
   assign rt_hit  = i_uses_rt && (i_id_ex.ctrl.write_reg == i_rt);
   assign o_stall = i_id_ex.ctrl.mem_read && (rs_hit || rt_hit);

   ////////////////////////////////////////////////////////////////////////////
   // Forward select
   ////////////////////////////////////////////////////////////////////////////

   // Youngest writer wins, MEM before WB
   function automatic fwd_src_t pick_src(input reg_idx_t src,
                                         input ex_mem_t  mem,
                                         input mem_wb_t  wb);
      fwd_src_t sel;
      if (mem.reg_write && mem.write_reg == src) begin
         sel = FWD_MEM;
      end else if (wb.reg_write && wb.write_reg == src) begin
         sel = FWD_WB;
      end else begin
         // Older writers already sit in the register file
         sel = FWD_RF;
      end
      return sel;
   endfunction

   assign o_fwd_a = pick_src(i_id_ex.rs, i_ex_mem, i_mem_wb);
   assign o_fwd_b = pick_src(i_id_ex.rt, i_ex_mem, i_mem_wb);

endmodule

`default_nettype wire

/* pipeline_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module pipeline_core (
   input  logic           clk,
   input  logic           reset_n,
   // Instruction fetch
   output cpu_pkg::word_t o_i_addr,
   output logic           o_i_read,
   input  cpu_pkg::word_t i_i_data,
   // Data memory
   output cpu_pkg::word_t o_d_addr,
   output logic           o_d_read,
   output logic           o_d_write,
   output cpu_pkg::word_t o_d_wdata,
   input  cpu_pkg::word_t i_d_data,
   // Output port
   output logic           o_out_valid,
   output cpu_pkg::word_t o_out_data,
   // Halt status
   output logic           o_halted
);
   import cpu_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Stage state
   ////////////////////////////////////////////////////////////////////////////

   word_t   pc;
   inst_t   if_id_inst;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   mem_wb_t mem_wb;

   // ID
   ctrl_t    id_ctrl;
   logic     id_uses_rs;
   logic     id_uses_rt;
   word_t    rf_rs_data;
   word_t    rf_rt_data;
   logic     stall;
   logic     halt_issued;
   logic     id_freeze;
   logic     id_bubble;

   // EX
   fwd_src_t fwd_a;
   fwd_src_t fwd_b;
   word_t    ex_a;
   word_t    ex_fwd_b;
   word_t    ex_b;
   word_t    alu_result;

   // MEM, output port, halt
   word_t    mem_value;
   logic     out_valid_q;
   word_t    out_data_q;
   logic     halt_latched;

   ////////////////////////////////////////////////////////////////////////////
   // Submodules
   ////////////////////////////////////////////////////////////////////////////

   control_decoder u_decoder (
      .i_inst (if_id_inst),
      .o_ctrl (id_ctrl)
   );

   register_file u_regs (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_rs      (if_id_inst.r.rs),
      .i_rt      (if_id_inst.r.rt),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data),
      .i_wb      (mem_wb)
   );

   hazard_unit u_hazard (
      .i_rs      (if_id_inst.r.rs),
      .i_rt      (if_id_inst.r.rt),
      .i_uses_rs (id_uses_rs),
      .i_uses_rt (id_uses_rt),
      .i_id_ex   (id_ex),
      .i_ex_mem  (ex_mem),
      .i_mem_wb  (mem_wb),
      .o_stall   (stall),
      .o_fwd_a   (fwd_a),
      .o_fwd_b   (fwd_b)
   );

   alu u_alu (
      .i_op     (id_ex.ctrl.alu_op),
      .i_a      (ex_a),
      .i_b      (ex_b),
      .o_result (alu_result)
   );

   ////////////////////////////////////////////////////////////////////////////
   // IF and ID
   ////////////////////////////////////////////////////////////////////////////

   // Fetch stops while HLT waits in ID
   assign o_i_addr = pc;
   assign o_i_read = !id_ctrl.halt;

   // Registers really read by the decoded instruction
   assign id_uses_rs = id_ctrl.mem_read || id_ctrl.mem_write || id_ctrl.out_write ||
                       (id_ctrl.reg_write && id_ctrl.alu_op != ALU_PASS_B);
   // Binary R-type ops and the store data
   assign id_uses_rt = id_ctrl.mem_write ||
                       (id_ctrl.reg_write && id_ctrl.b_src == B_REG &&
                        id_ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR});

   // HLT holds the front end for good
   assign id_freeze = stall || id_ctrl.halt;
   // HLT itself goes down once, then bubbles follow
   assign id_bubble = stall || (id_ctrl.halt && halt_issued);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc          <= '0;
         // Opcode 0 decodes to a bubble
         if_id_inst  <= '0;
         halt_issued <= 1'b0;
      end else begin
         if (!id_freeze) begin
            pc         <= pc + word_t'(1);
            if_id_inst <= i_i_data;
         end
         halt_issued <= halt_issued || id_ctrl.halt;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // EX
   ////////////////////////////////////////////////////////////////////////////

   // Same-cycle load data rides along with the MEM forward
   assign mem_value = (ex_mem.wb_src == WB_MEM) ? i_d_data : ex_mem.alu_out;

   function automatic word_t fwd_mux(input fwd_src_t sel,
                                     input word_t    rf_val,
                                     input word_t    mem_val,
                                     input word_t    wb_val);
      word_t val;
      case (sel)
         FWD_MEM: val = mem_val;
         FWD_WB:  val = wb_val;
         default: val = rf_val;
      endcase
      return val;
   endfunction

   assign ex_a     = fwd_mux(fwd_a, id_ex.a, mem_value, mem_wb.wb_data);
   assign ex_fwd_b = fwd_mux(fwd_b, id_ex.b, mem_value, mem_wb.wb_data);

   // Immediate forms of the second operand
   always_comb begin
      case (id_ex.ctrl.b_src)
         B_IMM_SIGNED: ex_b = {{(`WORD_SIZE-8){id_ex.imm8[7]}}, id_ex.imm8};
         B_IMM_ZERO:   ex_b = {{(`WORD_SIZE-8){1'b0}}, id_ex.imm8};
         B_IMM_HIGH:   ex_b = {id_ex.imm8, {(`WORD_SIZE-8){1'b0}}};
         default:      ex_b = ex_fwd_b;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stage registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         id_ex  <= '0;
         ex_mem <= '0;
         mem_wb <= '0;
      end else begin
         // ID to EX
         id_ex.ctrl <= id_bubble ? ctrl_t'('0) : id_ctrl;
         id_ex.a    <= rf_rs_data;
         id_ex.b    <= rf_rt_data;
         id_ex.imm8 <= if_id_inst.i.imm8;
         id_ex.rs   <= if_id_inst.r.rs;
         id_ex.rt   <= if_id_inst.r.rt;

         // EX to MEM
         ex_mem.reg_write  <= id_ex.ctrl.reg_write;
         ex_mem.wb_src     <= id_ex.ctrl.wb_src;
         ex_mem.write_reg  <= id_ex.ctrl.write_reg;
         ex_mem.mem_read   <= id_ex.ctrl.mem_read;
         ex_mem.mem_write  <= id_ex.ctrl.mem_write;
         ex_mem.halt       <= id_ex.ctrl.halt;
         ex_mem.alu_out    <= alu_result;
         // Store data is rt after forwarding
         ex_mem.store_data <= ex_fwd_b;

         // MEM to WB, value already resolved
         mem_wb.reg_write <= ex_mem.reg_write;
         mem_wb.write_reg <= ex_mem.write_reg;
         mem_wb.halt      <= ex_mem.halt;
         mem_wb.wb_data   <= mem_value;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memory, output port and halt
   ////////////////////////////////////////////////////////////////////////////

   assign o_d_addr  = ex_mem.alu_out;
   assign o_d_read  = ex_mem.mem_read;
   assign o_d_write = ex_mem.mem_write;
   assign o_d_wdata = ex_mem.store_data;

   // WWD strobe one cycle after EX
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         out_valid_q  <= 1'b0;
         halt_latched <= 1'b0;
      end else begin
         out_valid_q  <= id_ex.ctrl.out_write;
         // Sticky once HLT has reached WB
         halt_latched <= halt_latched || mem_wb.halt;
      end
   end

   // Forwarded rs value, kept between strobes
   always_ff @(posedge clk) begin
      if (id_ex.ctrl.out_write) begin
         out_data_q <= ex_a;
      end
   end

   assign o_out_valid = out_valid_q;
   assign o_out_data  = out_data_q;
   // High from the cycle HLT is in WB
   assign o_halted    = mem_wb.halt || halt_latched;

endmodule

`default_nettype wire

/* pipeline_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_assert (
   input logic clk,
   input logic reset_n,
   input logic i_halted,
   input logic i_d_read,
   input logic i_d_write,
   input logic i_out_valid
);

   // Halt is sticky until reset
   property halt_sticky;
      @(posedge clk) disable iff (!reset_n) i_halted |=> i_halted;
   endproperty

   // One data access per cycle
   property single_access;
      @(posedge clk) disable iff (!reset_n) !(i_d_read && i_d_write);
   endproperty

   // Strobes always resolved
   property strobes_known;
      @(posedge clk) disable iff (!reset_n) !$isunknown({i_out_valid, i_d_write});
   endproperty

   a_halt_sticky: assert property (halt_sticky)
      else $error("o_halted fell without a reset");
   a_single_access: assert property (single_access)
      else $error("o_d_read and o_d_write high together");
   a_strobes_known: assert property (strobes_known)
      else $error("o_out_valid or o_d_write unknown");

endmodule

bind pipeline_core pipeline_core_assert u_assert (
   .clk         (clk),
   .reset_n     (reset_n),
   .i_halted    (o_halted),
   .i_d_read    (o_d_read),
   .i_d_write   (o_d_write),
   .i_out_valid (o_out_valid)
);

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module register_file (
   input  logic              clk,
   input  logic              reset_n,
   input  cpu_pkg::reg_idx_t i_rs,
   input  cpu_pkg::reg_idx_t i_rt,
   output cpu_pkg::word_t    o_rs_data,
   output cpu_pkg::word_t    o_rt_data,
   input  cpu_pkg::mem_wb_t  i_wb
);
   import cpu_pkg::*;

   word_t regs [`NUM_REGS];

   // Writeback at the rising edge
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.reg_write) begin
         regs[i_wb.write_reg] <= i_wb.wb_data;
      end
   end

   // Write-through, a same-cycle write is seen by ID
   assign o_rs_data = (i_wb.reg_write && i_wb.write_reg == i_rs) ? i_wb.wb_data
                                                                  : regs[i_rs];
   assign o_rt_data = (i_wb.reg_write && i_wb.write_reg == i_rt) ? i_wb.wb_data
                                                                  : regs[i_rt];

endmodule

`default_nettype wire

/* tb_pipeline_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module tb_pipeline_core;
   import cpu_pkg::*;

   localparam int PROG_BODY    = 180;
   localparam int IMEM_DEPTH   = 256;
   localparam int DMEM_DEPTH   = 65536;
   localparam int HALT_TIMEOUT = 2000;

   localparam word_t HLT_WORD = {`OPCODE_RTYPE, 6'd0, `FUNC_HLT};

   logic   clk;
   logic   reset_n;
   word_t  i_addr;
   logic   i_read;
   word_t  i_data;
   word_t  d_addr;
   logic   d_read;
   logic   d_write;
   word_t  d_wdata;
   word_t  d_rdata;
   logic   out_valid;
   word_t  out_data;
   logic   halted;

   word_t  imem [IMEM_DEPTH];
   word_t  dmem [DMEM_DEPTH];
   word_t  model_dmem [DMEM_DEPTH];
   word_t  exp_out [$];
   integer seed;
   integer out_count;

   pipeline_core u_dut (
      .clk         (clk),
      .reset_n     (reset_n),
      .o_i_addr    (i_addr),
      .o_i_read    (i_read),
      .i_i_data    (i_data),
      .o_d_addr    (d_addr),
      .o_d_read    (d_read),
      .o_d_write   (d_write),
      .o_d_wdata   (d_wdata),
      .i_d_data    (d_rdata),
      .o_out_valid (out_valid),
      .o_out_data  (out_data),
      .o_halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memories
   ////////////////////////////////////////////////////////////////////////////

   // Combinational reads with HLT past the end of the program
   assign i_data  = (i_addr < IMEM_DEPTH) ? imem[i_addr] : HLT_WORD;
   // Data word only while the core reads
   assign d_rdata = d_read ? dmem[d_addr] : 'x;

   // Store lands at the strobe edge
   always @(posedge clk) begin
      if (d_write === 1'b1) begin
         dmem[d_addr] <= d_wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Failure reporting and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("ERROR: %s 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // Output words in program order
   always @(negedge clk) begin
      if (reset_n === 1'b1 && out_valid === 1'b1) begin
         if (out_count >= exp_out.size()) begin
            report_failure("Output port strobed more often than the program writes it");
         end else begin
            check_value("o_out_data", out_data, exp_out[out_count]);
         end
         out_count = out_count + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Program generation and reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic word_t enc_r(input logic [1:0] rs, input logic [1:0] rt,
                                   input logic [1:0] rd, input logic [5:0] fn);
      return {`OPCODE_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic word_t enc_i(input logic [3:0] op, input logic [1:0] rs,
                                   input logic [1:0] rt, input logic [7:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Byte swap keeps every address distinct
   task automatic fill_memories;
      integer a;
      word_t  w;
      for (a = 0; a < DMEM_DEPTH; a = a + 1) begin
         w = {a[7:0], a[15:8]} ^ 16'hc3a5;
         dmem[a]       = w;
         model_dmem[a] = w;
      end
      for (a = 0; a < IMEM_DEPTH; a = a + 1) begin
         imem[a] = HLT_WORD;
      end
   endtask

   task automatic build_program;
      integer      idx;
      integer      k;
      logic [31:0] rnd;
      logic [1:0]  r1;
      logic [1:0]  r2;
      logic [1:0]  r3;
      logic [7:0]  imm;
      idx = 0;
      while (idx < PROG_BODY) begin
         rnd = $random(seed);
         r1  = rnd[1:0];
         r2  = rnd[3:2];
         r3  = rnd[5:4];
         imm = rnd[15:8];
         case (rnd[19:16])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
               imem[idx] = enc_r(r1, r2, r3, {3'b000, rnd[22:20]});
               idx = idx + 1;
            end
            4'd6: begin
               imem[idx] = enc_i(`OPCODE_ADI, r1, r2, imm);
               idx = idx + 1;
            end
            4'd7: begin
               imem[idx] = enc_i(`OPCODE_ORI, r1, r2, imm);
               idx = idx + 1;
            end
            4'd8: begin
               imem[idx] = enc_i(`OPCODE_LHI, r1, r2, imm);
               idx = idx + 1;
            end
            4'd9: begin
               imem[idx] = enc_i(`OPCODE_LWD, r1, r2, imm);
               idx = idx + 1;
            end
            4'd10: begin
               imem[idx] = enc_i(`OPCODE_SWD, r1, r2, imm);
               idx = idx + 1;
            end
            4'd11: begin
               // Store then load back the same word
               imem[idx]     = enc_i(`OPCODE_SWD, r1, r2, imm);
               imem[idx + 1] = enc_i(`OPCODE_LWD, r1, r3, imm);
               idx = idx + 2;
            end
            4'd12: begin
               // Load-use into the output port
               imem[idx]     = enc_i(`OPCODE_LWD, r1, r2, imm);
               imem[idx + 1] = enc_r(r2, 2'd0, 2'd0, `FUNC_WWD);
               idx = idx + 2;
            end
            4'd13: begin
               // Load-use into the ALU
               imem[idx]     = enc_i(`OPCODE_LWD, r1, r2, imm);
               imem[idx + 1] = enc_r(r2, r1, r3, `FUNC_ADD);
               idx = idx + 2;
            end
            default: begin
               imem[idx] = enc_r(r1, 2'd0, 2'd0, `FUNC_WWD);
               idx = idx + 1;
            end
         endcase
      end
      // Dump every register and stop
      for (k = 0; k < 4; k = k + 1) begin
         imem[idx + k] = enc_r(k[1:0], 2'd0, 2'd0, `FUNC_WWD);
      end
      imem[idx + 4] = HLT_WORD;
      // Never executed
      for (k = 0; k < 4; k = k + 1) begin
         imem[idx + 5 + k] = enc_r(k[1:0], 2'd0, 2'd0, `FUNC_WWD);
      end
      imem[idx + 9] = enc_i(`OPCODE_SWD, 2'd0, 2'd1, 8'h10);
   endtask

   // One instruction per step, in program order
   task automatic run_model;
      word_t      regs [4];
      word_t      pc;
      word_t      w;
      word_t      simm;
      logic [1:0] rs;
      logic [1:0] rt;
      logic [1:0] rd;
      logic       done;
      integer     k;
      for (k = 0; k < 4; k = k + 1) begin
         regs[k] = '0;
      end
      pc   = '0;
      done = 1'b0;
      while (!done) begin
         w    = (pc < IMEM_DEPTH) ? imem[pc] : HLT_WORD;
         rs   = w[11:10];
         rt   = w[9:8];
         rd   = w[7:6];
         simm = {{8{w[7]}}, w[7:0]};
         case (w[15:12])
            `OPCODE_RTYPE: begin
               case (w[5:0])
                  `FUNC_ADD: regs[rd] = regs[rs] + regs[rt];
                  `FUNC_SUB: regs[rd] = regs[rs] - regs[rt];
                  `FUNC_AND: regs[rd] = regs[rs] & regs[rt];
                  `FUNC_ORR: regs[rd] = regs[rs] | regs[rt];
                  `FUNC_NOT: regs[rd] = ~regs[rs];
                  `FUNC_TCP: regs[rd] = 16'd0 - regs[rs];
                  `FUNC_SHL: regs[rd] = regs[rs] << 1;
                  `FUNC_SHR: regs[rd] = {regs[rs][15], regs[rs][15:1]};
                  `FUNC_WWD: exp_out.push_back(regs[rs]);
                  `FUNC_HLT: done = 1'b1;
                  default: ;
               endcase
            end
            `OPCODE_ADI: regs[rt] = regs[rs] + simm;
            `OPCODE_ORI: regs[rt] = regs[rs] | {8'h00, w[7:0]};
            `OPCODE_LHI: regs[rt] = {w[7:0], 8'h00};
            `OPCODE_LWD: regs[rt] = model_dmem[regs[rs] + simm];
            `OPCODE_SWD: model_dmem[regs[rs] + simm] = regs[rt];
            default: ;
         endcase
         pc = pc + 16'd1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      integer cycles;
      integer a;
      reset_n   = 1'b0;
      seed      = 32'h509e;
      out_count = 0;
      fill_memories();
      build_program();
      run_model();

      repeat (16) @(negedge clk);
      // Port state coming out of reset
      check_value("o_i_read", i_read, 1);
      check_value("o_d_read", d_read, 0);
      check_value("o_d_write", d_write, 0);
      check_value("o_out_valid", out_valid, 0);
      check_value("o_halted", halted, 0);
      reset_n = 1'b1;

      // Halt or give up
      cycles = 0;
      while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
         @(negedge clk);
         cycles = cycles + 1;
      end
      if (halted !== 1'b1) begin
         report_failure("Timeout: the core never raised o_halted");
      end else begin
         // Halt holds and nothing more retires
         repeat (8) begin
            @(negedge clk);
            check_value("o_halted", halted, 1);
         end
         check_value("wwd count", out_count, exp_out.size());
         for (a = 0; a < DMEM_DEPTH; a = a + 1) begin
            check_value($sformatf("dmem[%04h]", a), dmem[a], model_dmem[a]);
         end

         $display("all tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
cpu_pkg.sv
control_decoder.sv
register_file.sv
hazard_unit.sv
alu.sv
pipeline_core.sv
pipeline_core_assert.sv
tb_pipeline_core.sv
